//--- ecc_mem_pkg.sv
/* Shared widths, word types and controller states for the ECC word memory.
   Imported by the codec, storage, controller and top level. */

package ecc_mem_pkg;

  // Data word width; the codeword layout below assumes 8
  localparam int DATA_W = 8;

  // Hamming check bits covering positions 1..12
  localparam int CHECK_W = 4;

  // Data bits, check bits and one overall parity bit
  localparam int CODE_W = DATA_W + CHECK_W + 1;

  // Payload word as seen by the requester
  typedef logic [DATA_W-1:0] data_t;

  // Stored codeword
  // Bits 11:0 hold Hamming positions 12..1, bit 12 is overall even parity
  typedef logic [CODE_W-1:0] code_t;

  // Syndrome value is the Hamming position of a single flipped bit
  typedef logic [CHECK_W-1:0] syndrome_t;

  // Controller FSM states
  // Writes go IDLE, WRITE, ACK
  // Reads go IDLE, READ, DECODE, ACK
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    DECODE,
    ACK
  } ctrl_state_e;

endpackage

//--- ecc_mem_if.sv
/* Bus between the access controller and the codeword storage array.
   The controller side uses modport ctrl, the storage side uses modport mem. */

`timescale 1ns/1ps

interface ecc_mem_if #(
  parameter int addr_width = 4
);
  import ecc_mem_pkg::*;

  // Write strobe, one cycle per stored word
  logic mem_we;
  // Word address, shared by writes and reads
  logic [addr_width-1:0] mem_addr;
  // Codeword to store, fault mask already applied
  code_t mem_wcode;
  // Registered read word
  code_t mem_rcode;

  modport ctrl (
    output mem_we,
    output mem_addr,
    output mem_wcode,
    input  mem_rcode
  );

  modport mem (
    input  mem_we,
    input  mem_addr,
    input  mem_wcode,
    output mem_rcode
  );

endinterface

//--- hamming_encoder.sv
/* SEC-DED encoder, purely combinational.
   Maps an 8-bit data word to a 13-bit codeword with overall even parity on top. */

`timescale 1ns/1ps

module hamming_encoder (
  input  ecc_mem_pkg::data_t data,
  output ecc_mem_pkg::code_t code
);
  import ecc_mem_pkg::*;

  // Hamming part of the codeword, without the overall parity bit
  localparam int HAM_W = CODE_W - 1;

  logic [HAM_W:1] ham;

  always_comb begin
    int k;
    logic par;
    ham = '0;
    k = 0;
    // Data fills positions that are not a power of two, low bit first
    for (int p = 1; p <= HAM_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        ham[p] = data[k];
        k++;
      end
    end
    // Check bit c covers every position with bit c set
    // its own slot is still zero here, so it drops out of the sum
    for (int c = 0; c < CHECK_W; c++) begin
      par = 1'b0;
      for (int p = 1; p <= HAM_W; p++) begin
        if (p[c]) begin
          par ^= ham[p];
        end
      end
      ham[1 << c] = par;
    end
  end

  // Overall parity makes the whole 13-bit word even
  assign code = {^ham, ham};

endmodule

//--- hamming_decoder.sv
/* SEC-DED decoder, purely combinational.
   Corrects one flipped bit anywhere in the codeword and flags two flipped bits. */

`timescale 1ns/1ps

module hamming_decoder (
  input  ecc_mem_pkg::code_t code,
  output ecc_mem_pkg::data_t data,
  output logic               corrected,
  output logic               uncorrectable
);
  import ecc_mem_pkg::*;

  localparam int HAM_W = CODE_W - 1;

  syndrome_t      syndrome;
  logic           parity_err;
  logic [HAM_W:1] ham;

  // Recompute every check group over the received word
  always_comb begin
    syndrome = '0;
    for (int c = 0; c < CHECK_W; c++) begin
      for (int p = 1; p <= HAM_W; p++) begin
        if (p[c]) begin
          syndrome[c] ^= code[p-1];
        end
      end
    end
  end

  // Odd weight over all 13 bits means an odd number of flips
  assign parity_err = ^code;

  always_comb begin
    int k;
    ham           = code[HAM_W-1:0];
    corrected     = 1'b0;
    uncorrectable = 1'b0;
    data          = '0;
    k             = 0;
    if (parity_err) begin
      if (syndrome == '0) begin
        // Only the overall parity bit flipped, data is intact
        corrected = 1'b1;
      end else if (int'(syndrome) <= HAM_W) begin
        // Single error at the position named by the syndrome
        ham[syndrome] = ~ham[syndrome];
        corrected     = 1'b1;
      end else begin
        // Position past the word, cannot be a single error
        uncorrectable = 1'b1;
      end
    end else if (syndrome != '0) begin
      // Even number of flips with a non-zero syndrome
      uncorrectable = 1'b1;
    end
    // Pull the data field back out of the non-power-of-two slots
    for (int p = 1; p <= HAM_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        data[k] = ham[p];
        k++;
      end
    end
  end

endmodule

//--- ecc_storage_array.sv
/* Codeword storage, 2**addr_width words, single port.
   One write or one registered read per cycle, read data appears one edge later. */

`timescale 1ns/1ps

module ecc_storage_array #(
  parameter int addr_width = 4
) (
  input logic       clk,
  ecc_mem_if.mem    bus
);
  import ecc_mem_pkg::*;

  localparam int DEPTH = 2 ** addr_width;

  // Contents are undefined until written
  code_t words [DEPTH];

  // Write cycles update the array
  // every other cycle registers the addressed word onto mem_rcode
  always_ff @(posedge clk) begin
    if (bus.mem_we) begin
      words[bus.mem_addr] <= bus.mem_wcode;
    end else begin
      bus.mem_rcode <= words[bus.mem_addr];
    end
  end

endmodule

//--- ecc_mem_ctrl.sv
/* Access controller for the ECC memory.
   Runs the four-phase req/ack handshake, writes encoded words with the fault
   mask applied and captures decoder results on reads. */

`timescale 1ns/1ps

module ecc_mem_ctrl #(
  parameter int addr_width = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  logic                   we,
  input  logic [addr_width-1:0]  addr,
  input  ecc_mem_pkg::data_t     wdata,
  input  ecc_mem_pkg::code_t     flip_mask,
  output logic                   ack,
  output ecc_mem_pkg::data_t     rdata,
  output logic                   err_corrected,
  output logic                   err_uncorrectable,
  output ecc_mem_pkg::data_t     enc_data,
  input  ecc_mem_pkg::code_t     enc_code,
  input  ecc_mem_pkg::data_t     dec_data,
  input  logic                   dec_corrected,
  input  logic                   dec_uncorrectable,
  ecc_mem_if.ctrl                bus
);
  import ecc_mem_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;

  // Requester holds addr and wdata stable while req is high
  assign enc_data     = wdata;
  assign bus.mem_addr = addr;
  // Fault injection on the way into storage
  assign bus.mem_wcode = enc_code ^ flip_mask;
  // One write strobe per write access
  assign bus.mem_we    = (state == WRITE);

  // ack is high for the whole ACK state
  assign ack = (state == ACK);

  always_comb begin
    next_state = state;
    unique case (state)
      IDLE: begin
        if (req) begin
          next_state = we ? WRITE : READ;
        end
      end
      // Storage takes the word at the end of this cycle
      WRITE:  next_state = ACK;
      // Storage registers the addressed word at the end of this cycle
      READ:   next_state = DECODE;
      // Decoder sees mem_rcode now, results captured at this edge
      DECODE: next_state = ACK;
      ACK: begin
        // Stay here with results held until req is released
        if (!req) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= IDLE;
      rdata             <= '0;
      err_corrected     <= 1'b0;
      err_uncorrectable <= 1'b0;
    end else begin
      state <= next_state;
      // New access starts with clean flags
      if (state == IDLE && req) begin
        err_corrected     <= 1'b0;
        err_uncorrectable <= 1'b0;
      end
      if (state == DECODE) begin
        rdata             <= dec_data;
        err_corrected     <= dec_corrected;
        err_uncorrectable <= dec_uncorrectable;
      end
    end
  end

endmodule

//--- ecc_mem_top.sv
/* Top level of the ECC-protected word memory.
   Plain req/ack ports outside; controller, codec and storage wired inside. */

`timescale 1ns/1ps

module ecc_mem_top #(
  parameter int addr_width = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  logic                  we,
  input  logic [addr_width-1:0] addr,
  input  ecc_mem_pkg::data_t    wdata,
  input  ecc_mem_pkg::code_t    flip_mask,
  output logic                  ack,
  output ecc_mem_pkg::data_t    rdata,
  output logic                  err_corrected,
  output logic                  err_uncorrectable
);
  import ecc_mem_pkg::*;

  data_t enc_data;
  code_t enc_code;
  data_t dec_data;
  logic  dec_corrected;
  logic  dec_uncorrectable;

  // Controller to storage bus
  ecc_mem_if #(.addr_width(addr_width)) mem_bus ();

  hamming_encoder enc_i (
    .data (enc_data),
    .code (enc_code)
  );

  // Decoder works straight off the registered read word
  hamming_decoder dec_i (
    .code          (mem_bus.mem_rcode),
    .data          (dec_data),
    .corrected     (dec_corrected),
    .uncorrectable (dec_uncorrectable)
  );

  ecc_storage_array #(.addr_width(addr_width)) storage_i (
    .clk (clk),
    .bus (mem_bus.mem)
  );

  ecc_mem_ctrl #(.addr_width(addr_width)) ctrl_i (
    .clk               (clk),
    .rst               (rst),
    .req               (req),
    .we                (we),
    .addr              (addr),
    .wdata             (wdata),
    .flip_mask         (flip_mask),
    .ack               (ack),
    .rdata             (rdata),
    .err_corrected     (err_corrected),
    .err_uncorrectable (err_uncorrectable),
    .enc_data          (enc_data),
    .enc_code          (enc_code),
    .dec_data          (dec_data),
    .dec_corrected     (dec_corrected),
    .dec_uncorrectable (dec_uncorrectable),
    .bus               (mem_bus.ctrl)
  );

endmodule

//--- ecc_mem_props.sv
/* Handshake and error flag properties for the ECC memory controller.
   Bound into every ecc_mem_ctrl instance by the bind at the end. */

`timescale 1ns/1ps

module ecc_mem_props (
  input logic clk,
  input logic rst,
  input logic req,
  input logic we,
  input logic ack,
  input logic err_corrected,
  input logic err_uncorrectable,
  input logic mem_we
);

  // Controller leaves reset idle
  ack_low_after_reset: assert property (@(posedge clk) rst |=> !ack)
    else $error("ack high in the cycle after reset");

  // Back-pressure keeps ack up
  ack_held_with_req: assert property (@(posedge clk) disable iff (rst)
    (ack && req) |=> ack)
    else $error("ack dropped while req still high");

  // Release only follows a low req
  ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
    $fell(ack) |-> $past(!req))
    else $error("ack fell without req low");

  flags_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(err_corrected && err_uncorrectable))
    else $error("both error flags high");

  // Single strobe per write request
  mem_we_one_cycle: assert property (@(posedge clk) disable iff (rst)
    mem_we |=> !mem_we)
    else $error("mem_we high for more than one cycle");

  mem_we_from_write: assert property (@(posedge clk) disable iff (rst)
    mem_we |-> $past(req && we))
    else $error("mem_we without a write request");

  // Every new write request reaches storage on the next edge
  mem_we_per_write: assert property (@(posedge clk) disable iff (rst)
    ($rose(req) && we) |=> mem_we)
    else $error("write request without mem_we");

endmodule

bind ecc_mem_ctrl ecc_mem_props props_i (
  .clk               (clk),
  .rst               (rst),
  .req               (req),
  .we                (we),
  .ack               (ack),
  .err_corrected     (err_corrected),
  .err_uncorrectable (err_uncorrectable),
  .mem_we            (bus.mem_we)
);

//--- tb_ecc_mem.sv
/* Testbench for the ECC word memory.
   Replays accesses from the stim file over the req/ack handshake and checks
   read data, error flags and handshake timing against the expected columns. */

`timescale 1ns/1ps

module tb_ecc_mem;
  import ecc_mem_pkg::*;

  // Matches the DUT default address width
  localparam int addr_width = 4;
  localparam int CLK_HALF = 2;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_LINE = 20;
  // Falling edges from driving req to ack high, and from dropping req to ack low
  localparam int WRITE_LATENCY = 2;
  localparam int READ_LATENCY = 3;
  localparam int RELEASE_LATENCY = 1;
  // Upper bound on edges spent waiting for one ack change
  localparam int ACK_WAIT_MAX = 10;
  localparam string STIM_FILE = "ecc_mem_stim.txt";

  logic                  clk;
  logic                  rst;
  logic                  req;
  logic                  we;
  logic [addr_width-1:0] addr;
  data_t                 wdata;
  code_t                 flip_mask;
  logic                  ack;
  data_t                 rdata;
  logic                  err_corrected;
  logic                  err_uncorrectable;

  // One entry per access from the stim file
  logic                  st_we     [$];
  logic [addr_width-1:0] st_addr   [$];
  data_t                 st_wdata  [$];
  code_t                 st_flip   [$];
  data_t                 st_rdata  [$];
  logic                  st_corr   [$];
  logic                  st_unc    [$];
  int                    st_hold   [$];
  int                    st_line   [$];
  bit                    stim_loaded = 1'b0;
  // Stim line of the access in flight for error lines
  int                    cur_line = 0;

  ecc_mem_top #(.addr_width(addr_width)) dut_i (
    .clk               (clk),
    .rst               (rst),
    .req               (req),
    .we                (we),
    .addr              (addr),
    .wdata             (wdata),
    .flip_mask         (flip_mask),
    .ack               (ack),
    .rdata             (rdata),
    .err_corrected     (err_corrected),
    .err_uncorrectable (err_uncorrectable)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h (stim line %0d)",
               name, got, exp, cur_line);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          line_no;
    int          fields;
    string       line_buf;
    logic [31:0] f_we, f_addr, f_wdata, f_flip, f_rdata, f_corr, f_unc, f_hold;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stim file %s", STIM_FILE);
      $display("Simulation finished: FAIL");
      $fatal(1, "no stimulus");
    end else begin
      line_no = 0;
      while ($fgets(line_buf, fd) != 0) begin
        line_no++;
        fields = $sscanf(line_buf, "%h %h %h %h %h %h %h %h",
                         f_we, f_addr, f_wdata, f_flip, f_rdata, f_corr, f_unc, f_hold);
        // Comment and blank lines never parse as eight fields
        if (fields == 8) begin
          st_we.push_back(f_we[0]);
          st_addr.push_back(f_addr[addr_width-1:0]);
          st_wdata.push_back(f_wdata[DATA_W-1:0]);
          st_flip.push_back(f_flip[CODE_W-1:0]);
          st_rdata.push_back(f_rdata[DATA_W-1:0]);
          st_corr.push_back(f_corr[0]);
          st_unc.push_back(f_unc[0]);
          st_hold.push_back(int'(f_hold));
          st_line.push_back(line_no);
        end
      end
      $fclose(fd);
      if (st_we.size() == 0) begin
        $display("The stim file holds no accesses");
        $display("Simulation finished: FAIL");
        $fatal(1, "empty stimulus");
      end else begin
        stim_loaded = 1'b1;
      end
    end
  endtask

  // Full four-phase access for stim entry i with inputs driven on falling edges
  task automatic run_access(input int i);
    int    n;
    int    exp_lat;
    data_t held_rdata;
    logic  held_corr;
    logic  held_unc;
    @(negedge clk);
    // A new request may only start with ack low
    check_value("ack before req", ack, 1'b0);
    we        = st_we[i];
    addr      = st_addr[i];
    wdata     = st_wdata[i];
    flip_mask = st_flip[i];
    req       = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < ACK_WAIT_MAX);
    exp_lat = st_we[i] ? WRITE_LATENCY : READ_LATENCY;
    check_value("ack rise latency", n, exp_lat);
    // Data after a double error is undefined
    if (!st_we[i] && !st_unc[i]) begin
      check_value("rdata", rdata, st_rdata[i]);
    end
    check_value("err_corrected", err_corrected, st_corr[i]);
    check_value("err_uncorrectable", err_uncorrectable, st_unc[i]);
    held_rdata = rdata;
    held_corr  = err_corrected;
    held_unc   = err_uncorrectable;
    // Back-pressure keeps everything frozen until req drops
    repeat (st_hold[i]) begin
      @(negedge clk);
      check_value("ack held", ack, 1'b1);
      check_value("rdata held", rdata, held_rdata);
      check_value("err_corrected held", err_corrected, held_corr);
      check_value("err_uncorrectable held", err_uncorrectable, held_unc);
    end
    req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ack && n < ACK_WAIT_MAX);
    check_value("ack release latency", n, RELEASE_LATENCY);
  endtask

  initial begin
    rst       = 1'b1;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    flip_mask = '0;
    load_stim();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // Idle outputs straight after reset
    check_value("ack after reset", ack, 1'b0);
    check_value("rdata after reset", rdata, '0);
    check_value("err_corrected after reset", err_corrected, 1'b0);
    check_value("err_uncorrectable after reset", err_uncorrectable, 1'b0);
    for (int i = 0; i < st_we.size(); i++) begin
      cur_line = st_line[i];
      run_access(i);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog sized from the number of accesses
  initial begin
    int limit;
    wait (stim_loaded);
    limit = st_we.size() * CYCLES_PER_LINE + RESET_CYCLES;
    repeat (limit) @(posedge clk);
    $display("Timeout: the accesses did not finish within %0d clock cycles", limit);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- ecc_mem_stim.txt
# we addr wdata flip_mask exp_rdata exp_corr exp_unc hold, all hex, we 1 is a write
# flip_mask bit 12 is overall parity, bits 0 1 3 7 are check bits, the rest data
1 0 a5 0000 00 0 0 0
0 0 00 0000 a5 0 0 0
1 f 3c 0000 00 0 0 0
0 f 00 0000 3c 0 0 0
1 1 5a 0004 00 0 0 0
0 1 00 0000 5a 1 0 0
1 2 c3 0008 00 0 0 0
0 2 00 0000 c3 1 0 0
1 3 81 1000 00 0 0 0
0 3 00 0000 81 1 0 3
1 4 6e 0800 00 0 0 0
0 4 00 0000 6e 1 0 0
1 5 77 0005 00 0 0 0
0 5 00 0000 00 0 1 2
1 6 12 1004 00 0 0 0
0 6 00 0000 00 0 1 0
1 8 11 0000 00 0 0 0
1 9 22 0000 00 0 0 0
1 a 33 0000 00 0 0 0
0 a 00 0000 33 0 0 0
0 8 00 0000 11 0 0 1
0 9 00 0000 22 0 0 0
1 5 96 0000 00 0 0 0
0 5 00 0000 96 0 0 0
0 0 00 0000 a5 0 0 0

//--- flist.f
ecc_mem_pkg.sv
ecc_mem_if.sv
hamming_encoder.sv
hamming_decoder.sv
ecc_storage_array.sv
ecc_mem_ctrl.sv
ecc_mem_top.sv
ecc_mem_props.sv
tb_ecc_mem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ecc_mem
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
